// ==== vlog.f ====
src/execPkg.sv
src/instructionIssue.sv
src/simpleAlu.sv
src/loadStoreUnit.sv
src/writebackArbiter.sv
src/registerFile.sv
src/executeCore.sv
verification/executeCoreTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -f vlog.f --top-module executeCoreTb -o simv

output=$(./obj_dir/simv)
echo "$output"

if echo "$output" | grep -q "Result: PASSED"; then
    exit 0
else
    exit 1
fi

// ==== verification/executeCoreTb.sv ====
`timescale 1ns/1ps

module executeCoreTb;

    localparam int numCycles    = 800;
    localparam int gateStart    = 400;
    localparam int gateLength   = 6;
    localparam int drainTimeout = 60;

    logic        clk;
    logic        clkEn;
    logic        rst;
    logic        instValid;
    logic [3:0]  minorOpcode;
    logic [4:0]  unitSelect;
    logic [3:0]  srcRegA;
    logic [3:0]  srcRegB;
    logic [3:0]  destRegIn;
    logic        writebackEnIn;
    logic        issueStall;
    logic        branchEn;
    logic [15:0] branchOperand;
    logic        regWriteEn;
    logic [3:0]  regWriteAddr;
    logic [15:0] regWriteData;

    // Reference state of registers, memory and in-flight results
    logic [15:0] regModel [16];
    logic [15:0] memModel [256];
    logic [15:0] expData [16];
    bit          pending [16];
    int          unitOf [16];
    bit          aluBusy [2];
    int          lsuCnt;
    bit          lsuWait;
    logic [31:0] rngState;
    int          errors;
    int          checks;
    int          dispatchedWrites;
    int          writebacks;
    bit          dispatched;
    int          gateFrom;

    executeCore #(.dataWidth(16), .regAddrWidth(4), .memAddrWidth(8)) DUT (
        .clk(clk), .clkEn(clkEn), .rst(rst), .instValid(instValid),
        .minorOpcode(minorOpcode), .unitSelect(unitSelect),
        .srcRegA(srcRegA), .srcRegB(srcRegB), .destRegIn(destRegIn),
        .writebackEnIn(writebackEnIn), .issueStall(issueStall), .branchEn(branchEn),
        .branchOperand(branchOperand), .regWriteEn(regWriteEn),
        .regWriteAddr(regWriteAddr), .regWriteData(regWriteData)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic [15:0] aluModel(logic [3:0] op, logic [15:0] a, logic [15:0] b);
        case (op)
            4'd0: return a + b;
            4'd1: return a - b;
            4'd2: return a & b;
            4'd3: return a | b;
            4'd4: return a ^ b;
            4'd5: return a << b[3:0];
            4'd6: return a >> b[3:0];
            4'd7: return ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
            default: return 16'd0;
        endcase
    endfunction

    // First free register when scanning up from start
    function automatic logic [3:0] pickFree(logic [3:0] start);
        logic [3:0] idx;
        for (int i = 0; i < 16; i++) begin
            idx = start + i[3:0];
            if (!pending[idx]) begin
                return idx;
            end
        end
        return start;
    endfunction

    function automatic bit anyPending();
        for (int i = 0; i < 16; i++) begin
            if (pending[i]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // A finished result waits for the write port in the coming cycle
    function automatic bit requestHeld();
        return aluBusy[0] || aluBusy[1] || (lsuWait && lsuCnt == 0);
    endfunction

    task automatic checkValue(string name, logic [15:0] expected, logic [15:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic reportError(string msg);
        $display("ERROR: %s", msg);
        errors++;
    endtask

    // Runs at the falling edge where all DUT outputs are settled
    task automatic sampleCycle();
        logic        expStall;
        logic [15:0] a;
        logic [15:0] b;
        expStall = instValid && ((unitSelect[0] && aluBusy[0]) || (unitSelect[1] && aluBusy[1])
                   || (unitSelect[3] && (lsuCnt > 0 || lsuWait)));
        checkValue("issueStall", 16'(expStall), 16'(issueStall));
        if (!clkEn && regWriteEn) begin
            reportError("register write seen while the clock enable was low");
        end
        if (clkEn && regWriteEn) begin
            writebacks++;
            if (!pending[regWriteAddr]) begin
                reportError($sformatf("write to register %0d with no pending result",
                                      regWriteAddr));
            end else begin
                checkValue($sformatf("writeback r%0d", regWriteAddr),
                           expData[regWriteAddr], regWriteData);
                regModel[regWriteAddr] = expData[regWriteAddr];
                pending[regWriteAddr]  = 1'b0;
                if (unitOf[regWriteAddr] == 2) begin
                    lsuWait = 1'b0;
                end else begin
                    aluBusy[unitOf[regWriteAddr]] = 1'b0;
                end
            end
        end
        if (clkEn && lsuCnt > 0) begin
            lsuCnt--;
        end
        dispatched = clkEn && instValid && !expStall;
        // Branch port never stalls
        checkValue("branchEn", 16'(instValid && unitSelect[4]), 16'(branchEn));
        if (dispatched) begin
            a = regModel[srcRegA];
            b = regModel[srcRegB];
            if (unitSelect[4]) begin
                checkValue("branchOperand", a, branchOperand);
            end else if (unitSelect[3]) begin
                lsuCnt = 2;
                if (minorOpcode == 4'd1) begin
                    memModel[a[7:0]] = b;
                end else if (writebackEnIn) begin
                    expData[destRegIn] = memModel[a[7:0]];
                    pending[destRegIn] = 1'b1;
                    unitOf[destRegIn]  = 2;
                    lsuWait            = 1'b1;
                    dispatchedWrites++;
                end
            end else if (writebackEnIn) begin
                expData[destRegIn]  = aluModel(minorOpcode, a, b);
                pending[destRegIn]  = 1'b1;
                unitOf[destRegIn]   = unitSelect[1] ? 1 : 0;
                aluBusy[unitSelect[1] ? 1 : 0] = 1'b1;
                dispatchedWrites++;
            end
        end
    endtask

    // Runs at the rising edge and holds a stalled instruction unchanged
    task automatic driveCycle(int cycle);
        logic [31:0] r;
        bit          gated;
        // Gate opens once a result is waiting for the write port
        if (gateFrom < 0 && cycle >= gateStart && requestHeld()) begin
            gateFrom = cycle;
        end
        gated = (gateFrom >= 0) && (cycle < gateFrom + gateLength);
        clkEn <= !gated;
        if (gated) begin
            instValid <= 1'b0;
        end else if (dispatched || !instValid) begin
            r = nextRand();
            instValid <= r[0] | r[1];
            case (r[3:2])
                2'd0: unitSelect <= 5'b00001;
                2'd1: unitSelect <= 5'b00010;
                2'd2: unitSelect <= 5'b01000;
                default: unitSelect <= 5'b10000;
            endcase
            minorOpcode   <= (r[3:2] == 2'd2) ? {3'b000, r[4]} : {1'b0, r[6:4]};
            srcRegA       <= pickFree(r[11:8]);
            srcRegB       <= pickFree(r[15:12]);
            destRegIn     <= pickFree(r[19:16]);
            writebackEnIn <= (r[22:20] != 3'd0);
        end
    endtask

    initial begin
        int waited;
        clkEn         = 1'b1;
        rst           = 1'b1;
        instValid     = 1'b0;
        minorOpcode   = 4'd0;
        unitSelect    = 5'd0;
        srcRegA       = 4'd0;
        srcRegB       = 4'd0;
        destRegIn     = 4'd0;
        writebackEnIn = 1'b0;
        rngState      = 32'd90965;
        errors        = 0;
        checks        = 0;
        dispatched    = 1'b0;
        gateFrom      = -1;
        lsuCnt        = 0;
        lsuWait       = 1'b0;
        aluBusy[0]    = 1'b0;
        aluBusy[1]    = 1'b0;
        for (int i = 0; i < 16; i++) begin
            regModel[i] = '0;
            pending[i]  = 1'b0;
            unitOf[i]   = 0;
        end
        for (int i = 0; i < 256; i++) begin
            memModel[i] = '0;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkValue("reset regWriteEn", 16'd0, 16'(regWriteEn));
        checkValue("reset branchEn", 16'd0, 16'(branchEn));
        checkValue("reset issueStall", 16'd0, 16'(issueStall));
        for (int c = 0; c < numCycles; c++) begin
            @(posedge clk);
            driveCycle(c);
            @(negedge clk);
            sampleCycle();
        end
        @(posedge clk);
        instValid <= 1'b0;
        waited = 0;
        while (waited < drainTimeout) begin
            @(negedge clk);
            sampleCycle();
            if (!anyPending()) begin
                break;
            end
            @(posedge clk);
            waited++;
        end
        if (anyPending()) begin
            reportError("timeout while waiting for pending writes to complete");
        end
        if (dispatchedWrites != writebacks) begin
            reportError("number of writebacks differs from dispatched writing instructions");
        end
        if (gateFrom < 0) begin
            reportError("clock enable window never started with a result waiting");
        end
        $display("Checks: %0d, errors: %0d, dispatched writes: %0d, writebacks: %0d",
                 checks, errors, dispatchedWrites, writebacks);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== src/executeCore.sv ====
`timescale 1ns/1ps

module executeCore import execPkg::*; #(
    parameter int dataWidth    = 16,
    parameter int regAddrWidth = 4,
    parameter int memAddrWidth = 8
)(
    input  logic                    clk,
    input  logic                    clkEn,
    input  logic                    rst,
    input  logic                    instValid,
    input  logic [3:0]              minorOpcode,
    input  logic [NUM_UNITS-1:0]    unitSelect,
    input  logic [regAddrWidth-1:0] srcRegA,
    input  logic [regAddrWidth-1:0] srcRegB,
    input  logic [regAddrWidth-1:0] destRegIn,
    input  logic                    writebackEnIn,

    output logic                    issueStall,
    output logic                    branchEn,
    output logic [dataWidth-1:0]    branchOperand,
    output logic                    regWriteEn,
    output logic [regAddrWidth-1:0] regWriteAddr,
    output logic [dataWidth-1:0]    regWriteData
);

    logic [dataWidth-1:0]    regAData;
    logic [dataWidth-1:0]    regBData;
    logic [3:0]              aluOp;
    logic [dataWidth-1:0]    dataB;
    logic [regAddrWidth-1:0] destReg;
    logic                    writebackEn;
    logic                    alu0En;
    logic                    alu1En;
    logic                    lsuEn;
    logic                    alu0Ready;
    logic                    alu1Ready;
    logic                    lsuReady;
    logic [NUM_WB_PORTS-1:0] wbReq;
    logic [NUM_WB_PORTS-1:0] wbGrant;
    logic [regAddrWidth-1:0] wbAddr0;
    logic [regAddrWidth-1:0] wbAddr1;
    logic [regAddrWidth-1:0] wbAddr2;
    logic [dataWidth-1:0]    wbData0;
    logic [dataWidth-1:0]    wbData1;
    logic [dataWidth-1:0]    wbData2;

    registerFile #(.dataWidth(dataWidth), .regAddrWidth(regAddrWidth)) regFile (
        .clk(clk), .clkEn(clkEn), .rst(rst),
        .readAddrA(srcRegA), .readAddrB(srcRegB),
        .writeEn(regWriteEn), .writeAddr(regWriteAddr), .writeData(regWriteData),
        .readDataA(regAData), .readDataB(regBData)
    );

    // Operand A doubles as the branch operand for the outside PC
    instructionIssue #(.dataWidth(dataWidth), .regAddrWidth(regAddrWidth)) issue (
        .instValid(instValid), .minorOpcode(minorOpcode), .unitSelect(unitSelect),
        .destRegIn(destRegIn), .writebackEnIn(writebackEnIn),
        .regAData(regAData), .regBData(regBData),
        .alu0Ready(alu0Ready), .alu1Ready(alu1Ready), .lsuReady(lsuReady),
        .aluOp(aluOp), .dataA(branchOperand), .dataB(dataB),
        .destReg(destReg), .writebackEn(writebackEn),
        .alu0En(alu0En), .alu1En(alu1En), .lsuEn(lsuEn),
        .branchEn(branchEn), .issueStall(issueStall)
    );

    simpleAlu #(.dataWidth(dataWidth), .regAddrWidth(regAddrWidth)) alu0 (
        .clk(clk), .clkEn(clkEn), .rst(rst), .en(alu0En), .aluOp(aluOp),
        .dataA(branchOperand), .dataB(dataB), .destReg(destReg),
        .writebackEn(writebackEn), .wbGrant(wbGrant[0]),
        .ready(alu0Ready), .wbReq(wbReq[0]), .wbAddr(wbAddr0), .wbData(wbData0)
    );

    simpleAlu #(.dataWidth(dataWidth), .regAddrWidth(regAddrWidth)) alu1 (
        .clk(clk), .clkEn(clkEn), .rst(rst), .en(alu1En), .aluOp(aluOp),
        .dataA(branchOperand), .dataB(dataB), .destReg(destReg),
        .writebackEn(writebackEn), .wbGrant(wbGrant[1]),
        .ready(alu1Ready), .wbReq(wbReq[1]), .wbAddr(wbAddr1), .wbData(wbData1)
    );

    loadStoreUnit #(
        .dataWidth(dataWidth), .regAddrWidth(regAddrWidth), .memAddrWidth(memAddrWidth)
    ) lsu (
        .clk(clk), .clkEn(clkEn), .rst(rst), .en(lsuEn), .aluOp(aluOp),
        .dataA(branchOperand), .dataB(dataB), .destReg(destReg),
        .writebackEn(writebackEn), .wbGrant(wbGrant[2]),
        .ready(lsuReady), .wbReq(wbReq[2]), .wbAddr(wbAddr2), .wbData(wbData2)
    );

    writebackArbiter #(.dataWidth(dataWidth), .regAddrWidth(regAddrWidth)) arbiter (
        .clk(clk), .clkEn(clkEn), .rst(rst), .wbReq(wbReq),
        .wbAddr0(wbAddr0), .wbAddr1(wbAddr1), .wbAddr2(wbAddr2),
        .wbData0(wbData0), .wbData1(wbData1), .wbData2(wbData2),
        .wbGrant(wbGrant), .regWriteEn(regWriteEn),
        .regWriteAddr(regWriteAddr), .regWriteData(regWriteData)
    );

endmodule

// ==== src/registerFile.sv ====
`timescale 1ns/1ps

module registerFile #(
    parameter int dataWidth    = 16,
    parameter int regAddrWidth = 4
)(
    input  logic                    clk,
    input  logic                    clkEn,
    input  logic                    rst,
    input  logic [regAddrWidth-1:0] readAddrA,
    input  logic [regAddrWidth-1:0] readAddrB,
    input  logic                    writeEn,
    input  logic [regAddrWidth-1:0] writeAddr,
    input  logic [dataWidth-1:0]    writeData,

    output logic [dataWidth-1:0]    readDataA,
    output logic [dataWidth-1:0]    readDataB
);

    logic [dataWidth-1:0] regs [2**regAddrWidth];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**regAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (clkEn && writeEn) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Reads see the old value during a write to the same register
    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

endmodule

// ==== src/writebackArbiter.sv ====
`timescale 1ns/1ps

module writebackArbiter import execPkg::*; #(
    parameter int dataWidth    = 16,
    parameter int regAddrWidth = 4
)(
    input  logic                    clk,
    input  logic                    clkEn,
    input  logic                    rst,
    input  logic [NUM_WB_PORTS-1:0] wbReq,
    input  logic [regAddrWidth-1:0] wbAddr0,
    input  logic [regAddrWidth-1:0] wbAddr1,
    input  logic [regAddrWidth-1:0] wbAddr2,
    input  logic [dataWidth-1:0]    wbData0,
    input  logic [dataWidth-1:0]    wbData1,
    input  logic [dataWidth-1:0]    wbData2,

    output logic [NUM_WB_PORTS-1:0] wbGrant,
    output logic                    regWriteEn,
    output logic [regAddrWidth-1:0] regWriteAddr,
    output logic [dataWidth-1:0]    regWriteData
);

    localparam int ptrWidth = $clog2(NUM_WB_PORTS);

    logic [ptrWidth-1:0] priorityPtr;
    logic [ptrWidth-1:0] winner;

    // Scan from the pointer around the ring, first requester wins
    always_comb begin
        int idx;
        wbGrant    = '0;
        regWriteEn = 1'b0;
        winner     = '0;
        for (int i = 0; i < NUM_WB_PORTS; i++) begin
            idx = int'(priorityPtr) + i;
            if (idx >= NUM_WB_PORTS) begin
                idx = idx - NUM_WB_PORTS;
            end
            if (clkEn && !regWriteEn && wbReq[idx]) begin
                wbGrant[idx] = 1'b1;
                regWriteEn   = 1'b1;
                winner       = idx[ptrWidth-1:0];
            end
        end
    end

    always_comb begin
        case (winner)
            2'd1: begin
                regWriteAddr = wbAddr1;
                regWriteData = wbData1;
            end
            2'd2: begin
                regWriteAddr = wbAddr2;
                regWriteData = wbData2;
            end
            default: begin
                regWriteAddr = wbAddr0;
                regWriteData = wbData0;
            end
        endcase
    end

    // Next requester after the winner gets top priority
    always_ff @(posedge clk) begin
        if (rst) begin
            priorityPtr <= '0;
        end else if (clkEn && regWriteEn) begin
            if (int'(winner) == NUM_WB_PORTS - 1) begin
                priorityPtr <= '0;
            end else begin
                priorityPtr <= winner + 1'b1;
            end
        end
    end

endmodule

// ==== src/loadStoreUnit.sv ====
`timescale 1ns/1ps

module loadStoreUnit import execPkg::*; #(
    parameter int dataWidth    = 16,
    parameter int regAddrWidth = 4,
    parameter int memAddrWidth = 8
)(
    input  logic                    clk,
    input  logic                    clkEn,
    input  logic                    rst,
    input  logic                    en,
    input  logic [3:0]              aluOp,
    input  logic [dataWidth-1:0]    dataA,
    input  logic [dataWidth-1:0]    dataB,
    input  logic [regAddrWidth-1:0] destReg,
    input  logic                    writebackEn,
    input  logic                    wbGrant,

    output logic                    ready,
    output logic                    wbReq,
    output logic [regAddrWidth-1:0] wbAddr,
    output logic [dataWidth-1:0]    wbData
);

    localparam logic [1:0] STATE_IDLE   = 2'd0;
    localparam logic [1:0] STATE_ACCESS = 2'd1;
    localparam logic [1:0] STATE_SECOND = 2'd2;
    localparam logic [1:0] STATE_WAIT   = 2'd3;

    logic [1:0]              state;
    logic                    isStore;
    logic                    wbPending;
    logic [memAddrWidth-1:0] memAddr;
    logic [dataWidth-1:0]    storeData;
    logic [dataWidth-1:0]    mem [2**memAddrWidth];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= STATE_IDLE;
            for (int i = 0; i < 2**memAddrWidth; i++) begin
                mem[i] <= '0;
            end
        end else if (clkEn) begin
            case (state)
                STATE_IDLE: begin
                    if (en) begin
                        state <= STATE_ACCESS;
                    end
                end
                STATE_ACCESS: state <= STATE_SECOND;
                STATE_SECOND: begin
                    if (isStore) begin
                        mem[memAddr] <= storeData;
                        state        <= STATE_IDLE;
                    end else begin
                        // Loads without writeback finish silently
                        state <= wbPending ? STATE_WAIT : STATE_IDLE;
                    end
                end
                STATE_WAIT: begin
                    if (wbGrant) begin
                        state <= STATE_IDLE;
                    end
                end
                default: state <= STATE_IDLE;
            endcase
        end
    end

    // Request fields captured at the strobe, load word on the second cycle
    always_ff @(posedge clk) begin
        if (clkEn) begin
            if (state == STATE_IDLE && en) begin
                isStore   <= (lsuOpT'(aluOp) == STORE);
                wbPending <= writebackEn;
                memAddr   <= dataA[memAddrWidth-1:0];
                storeData <= dataB;
                wbAddr    <= destReg;
            end
            if (state == STATE_SECOND && !isStore) begin
                wbData <= mem[memAddr];
            end
        end
    end

    assign ready = (state == STATE_IDLE);
    assign wbReq = (state == STATE_WAIT);

endmodule

// ==== src/simpleAlu.sv ====
`timescale 1ns/1ps

module simpleAlu import execPkg::*; #(
    parameter int dataWidth    = 16,
    parameter int regAddrWidth = 4
)(
    input  logic                    clk,
    input  logic                    clkEn,
    input  logic                    rst,
    input  logic                    en,
    input  logic [3:0]              aluOp,
    input  logic [dataWidth-1:0]    dataA,
    input  logic [dataWidth-1:0]    dataB,
    input  logic [regAddrWidth-1:0] destReg,
    input  logic                    writebackEn,
    input  logic                    wbGrant,

    output logic                    ready,
    output logic                    wbReq,
    output logic [regAddrWidth-1:0] wbAddr,
    output logic [dataWidth-1:0]    wbData
);

    logic [dataWidth-1:0] result;
    logic                 holdValid;

    always_comb begin
        case (aluOpT'(aluOp))
            ADD:     result = dataA + dataB;
            SUB:     result = dataA - dataB;
            AND:     result = dataA & dataB;
            OR:      result = dataA | dataB;
            XOR:     result = dataA ^ dataB;
            SHL:     result = dataA << dataB[3:0];
            SHR:     result = dataA >> dataB[3:0];
            SLT:     result = {{(dataWidth-1){1'b0}}, $signed(dataA) < $signed(dataB)};
            default: result = '0;
        endcase
    end

    // One-entry holder stays full until the arbiter takes it
    always_ff @(posedge clk) begin
        if (rst) begin
            holdValid <= 1'b0;
        end else if (clkEn) begin
            if (en) begin
                holdValid <= writebackEn;
            end else if (wbGrant) begin
                holdValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clkEn && en) begin
            wbAddr <= destReg;
            wbData <= result;
        end
    end

    assign ready = !holdValid;
    assign wbReq = holdValid;

endmodule

// ==== src/instructionIssue.sv ====
`timescale 1ns/1ps

module instructionIssue import execPkg::*; #(
    parameter int dataWidth    = 16,
    parameter int regAddrWidth = 4
)(
    input  logic                    instValid,
    input  logic [3:0]              minorOpcode,
    input  logic [NUM_UNITS-1:0]    unitSelect,
    input  logic [regAddrWidth-1:0] destRegIn,
    input  logic                    writebackEnIn,
    input  logic [dataWidth-1:0]    regAData,
    input  logic [dataWidth-1:0]    regBData,
    input  logic                    alu0Ready,
    input  logic                    alu1Ready,
    input  logic                    lsuReady,

    output logic [3:0]              aluOp,
    output logic [dataWidth-1:0]    dataA,
    output logic [dataWidth-1:0]    dataB,
    output logic [regAddrWidth-1:0] destReg,
    output logic                    writebackEn,
    output logic                    alu0En,
    output logic                    alu1En,
    output logic                    lsuEn,
    output logic                    branchEn,
    output logic                    issueStall
);

    logic [NUM_UNITS-1:0] activeSelect;

    // Complex ALU slot is reserved, its select bit is dropped
    assign activeSelect = instValid ? (unitSelect & ~(NUM_UNITS'(1) << UNIT_CPLX)) : '0;

    // Stall when the selected unit still holds earlier work
    assign issueStall = (activeSelect[UNIT_ALU0] && !alu0Ready) ||
                        (activeSelect[UNIT_ALU1] && !alu1Ready) ||
                        (activeSelect[UNIT_LSU]  && !lsuReady);

    assign alu0En   = activeSelect[UNIT_ALU0] && !issueStall;
    assign alu1En   = activeSelect[UNIT_ALU1] && !issueStall;
    assign lsuEn    = activeSelect[UNIT_LSU]  && !issueStall;
    // Branch port has no ready and never stalls on its own
    assign branchEn = activeSelect[UNIT_BRANCH] && !issueStall;

    // Operands and writeback control are shared by every unit
    assign aluOp       = minorOpcode;
    assign dataA       = regAData;
    assign dataB       = regBData;
    assign destReg     = destRegIn;
    assign writebackEn = writebackEnIn;

endmodule

// ==== src/execPkg.sv ====
package execPkg;

    // Bit positions in the one-hot unit select
    localparam int UNIT_ALU0   = 0;
    localparam int UNIT_ALU1   = 1;
    localparam int UNIT_CPLX   = 2;
    localparam int UNIT_LSU    = 3;
    localparam int UNIT_BRANCH = 4;
    localparam int NUM_UNITS   = 5;

    // Requesters on the register write port: ALU0, ALU1, LSU
    localparam int NUM_WB_PORTS = 3;

    // Minor opcodes seen by the simple ALUs
    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        SHL = 4'd5,
        SHR = 4'd6,
        SLT = 4'd7
    } aluOpT;

    // Same minor opcode field as seen by the LSU
    typedef enum logic [3:0] {
        LOAD  = 4'd0,
        STORE = 4'd1
    } lsuOpT;

endpackage
